// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
RTL_TOP   ?= mem_subsys
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
mem_pkg.sv
fetch_port.sv
data_port.sv
mem_arbiter.sv
word_ram.sv
mem_subsys.sv
mem_subsys_asserts.sv
tb_mem_subsys.sv

// File: data_port.sv
`timescale 1ns/1ps
`default_nettype none

module data_port (
    input  mem_pkg::addr_t    data_addr,
    input  mem_pkg::word_t    data_wdata,
    input  mem_pkg::mask_t    data_mask,
    input  logic              data_r_en,
    input  logic              data_w_en,
    input  logic              done,
    input  mem_pkg::word_t    rsp_data,
    output mem_pkg::word_t    data_rdata,
    output logic              data_finish,
    output logic              req,
    output mem_pkg::mem_req_t req_pkt
);
    import mem_pkg::*;

    assign req         = data_r_en || data_w_en;
    assign data_finish = done;

    always_comb begin
        req_pkt.addr  = {data_addr[$bits(addr_t)-1:2], 2'b00};
        req_pkt.write = data_w_en;
        // Store data and mask move up to the addressed lane, upper bytes fall off
        case (data_addr[1:0])
            2'b00: begin
                req_pkt.wdata = data_wdata;
                req_pkt.mask  = data_mask;
            end
            2'b01: begin
                req_pkt.wdata = {data_wdata[23:0], 8'b0};
                req_pkt.mask  = {data_mask[2:0], 1'b0};
            end
            2'b10: begin
                req_pkt.wdata = {data_wdata[15:0], 16'b0};
                req_pkt.mask  = {data_mask[1:0], 2'b0};
            end
            default: begin
                req_pkt.wdata = {data_wdata[7:0], 24'b0};
                req_pkt.mask  = {data_mask[0], 3'b0};
            end
        endcase
    end

    // Loads come back zero-filled, the core does any sign extension
    always_comb begin
        case (data_addr[1:0])
            2'b00:   data_rdata = rsp_data;
            2'b01:   data_rdata = {8'b0, rsp_data[31:8]};
            2'b10:   data_rdata = {16'b0, rsp_data[31:16]};
            default: data_rdata = {24'b0, rsp_data[31:24]};
        endcase
    end

endmodule

`default_nettype wire

// File: fetch_port.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_port (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::addr_t    fetch_addr,
    input  logic              fetch_en,
    input  logic              done,
    input  mem_pkg::word_t    rsp_data,
    input  logic              wr_done,
    output mem_pkg::word_t    fetch_data,
    output logic              fetch_finish,
    output logic              req,
    output mem_pkg::mem_req_t req_pkt
);
    import mem_pkg::*;

    logic [$bits(addr_t)-3:0] buf_tag;
    word_t                    buf_data;
    logic                     buf_valid;
    logic                     hit;
    logic                     hit_pend;

    assign hit = fetch_en && buf_valid && (buf_tag == fetch_addr[$bits(addr_t)-1:2]);

    // No RAM request while a buffer hit is being answered
    assign req = fetch_en && !hit && !hit_pend;

    always_comb begin
        req_pkt.addr  = {fetch_addr[$bits(addr_t)-1:2], 2'b00};
        req_pkt.wdata = '0;
        req_pkt.mask  = '0;
        req_pkt.write = 1'b0;
    end

    assign fetch_data   = hit_pend ? buf_data : rsp_data;
    assign fetch_finish = hit_pend || done;

    // The request is still held in the cycle of its own finish, so a hit
    // in that cycle must not start a second pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            hit_pend <= 1'b0;
        end else begin
            hit_pend <= hit && !hit_pend;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid <= 1'b0;
        end else if (wr_done) begin
            buf_valid <= 1'b0;
        end else if (done) begin
            buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            buf_tag  <= fetch_addr[$bits(addr_t)-1:2];
            buf_data <= rsp_data;
        end
    end

endmodule

`default_nettype wire

// File: mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic              clk,
    input  logic              rst,
    input  logic              f_req,
    input  mem_pkg::mem_req_t f_pkt,
    input  logic              d_req,
    input  mem_pkg::mem_req_t d_pkt,
    input  mem_pkg::word_t    ram_rdata,
    input  logic              ram_ready,
    output logic              ram_valid,
    output mem_pkg::mem_req_t ram_req,
    output mem_pkg::word_t    rsp_data,
    output logic              f_done,
    output logic              d_done,
    output logic              wr_done
);
    import mem_pkg::*;

    arb_state_t state;
    logic       last_fetch;
    logic       owner_fetch;
    logic       owner_write;
    logic       grant_f;
    logic       grant_d;
    logic       rsp_cycle;

    // Data wins a tie unless it was the one served last
    assign grant_d = d_req && (!f_req || last_fetch);
    assign grant_f = f_req && !grant_d;

    assign ram_valid = (state == ARB_IDLE) && (f_req || d_req);
    assign ram_req   = grant_d ? d_pkt : f_pkt;

    assign rsp_cycle = (state == ARB_WAIT) && ram_ready;
    assign rsp_data  = ram_rdata;
    assign f_done    = rsp_cycle && owner_fetch;
    assign d_done    = rsp_cycle && !owner_fetch;
    assign wr_done   = d_done && owner_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ARB_IDLE;
            last_fetch  <= 1'b1;
            owner_fetch <= 1'b0;
            owner_write <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (ram_valid) begin
                        state       <= ARB_WAIT;
                        owner_fetch <= grant_f;
                        owner_write <= grant_d && d_pkt.write;
                        last_fetch  <= grant_f;
                    end
                end
                // The RAM always answers in the cycle after the issue
                ARB_WAIT: begin
                    state <= ARB_IDLE;
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

    // Byte lanes in one memory word
    localparam int LANES  = 4;
    localparam int BYTE_W = 8;

    // One memory word
    typedef logic [LANES*BYTE_W-1:0] word_t;

    // Byte address
    typedef logic [31:0] addr_t;

    // One enable bit per byte lane
    typedef logic [LANES-1:0] mask_t;

    // A word-wide RAM request as produced by either port
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        mask_t mask;
        logic  write;
    } mem_req_t;

    // The RAM access is a single issue cycle followed by the response cycle
    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_WAIT = 1'b1
    } arb_state_t;

endpackage

`default_nettype wire

// File: mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys #(
    parameter int DEPTH_LOG2 = 8
) (
    input  logic           clk,
    input  logic           rst,
    input  mem_pkg::addr_t fetch_addr,
    input  logic           fetch_en,
    output mem_pkg::word_t fetch_data,
    output logic           fetch_finish,
    input  mem_pkg::addr_t data_addr,
    input  mem_pkg::word_t data_wdata,
    input  mem_pkg::mask_t data_mask,
    input  logic           data_r_en,
    input  logic           data_w_en,
    output mem_pkg::word_t data_rdata,
    output logic           data_finish
);
    import mem_pkg::*;

    logic     f_req;
    logic     d_req;
    mem_req_t f_pkt;
    mem_req_t d_pkt;
    word_t    rsp_data;
    logic     f_done;
    logic     d_done;
    logic     wr_done;
    mem_req_t ram_req;
    logic     ram_valid;
    word_t    ram_rdata;
    logic     ram_ready;

    fetch_port u_fetch (
        .clk          (clk),
        .rst          (rst),
        .fetch_addr   (fetch_addr),
        .fetch_en     (fetch_en),
        .done         (f_done),
        .rsp_data     (rsp_data),
        .wr_done      (wr_done),
        .fetch_data   (fetch_data),
        .fetch_finish (fetch_finish),
        .req          (f_req),
        .req_pkt      (f_pkt)
    );

    data_port u_data (
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_mask   (data_mask),
        .data_r_en   (data_r_en),
        .data_w_en   (data_w_en),
        .done        (d_done),
        .rsp_data    (rsp_data),
        .data_rdata  (data_rdata),
        .data_finish (data_finish),
        .req         (d_req),
        .req_pkt     (d_pkt)
    );

    mem_arbiter u_arb (
        .clk       (clk),
        .rst       (rst),
        .f_req     (f_req),
        .f_pkt     (f_pkt),
        .d_req     (d_req),
        .d_pkt     (d_pkt),
        .ram_rdata (ram_rdata),
        .ram_ready (ram_ready),
        .ram_valid (ram_valid),
        .ram_req   (ram_req),
        .rsp_data  (rsp_data),
        .f_done    (f_done),
        .d_done    (d_done),
        .wr_done   (wr_done)
    );

    word_ram #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) u_ram (
        .clk       (clk),
        .rst       (rst),
        .ram_valid (ram_valid),
        .ram_req   (ram_req),
        .ram_rdata (ram_rdata),
        .ram_ready (ram_ready)
    );

endmodule

`default_nettype wire

// File: mem_subsys_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_asserts (
    input logic                clk,
    input logic                rst,
    input logic                fetch_finish,
    input logic                data_r_en,
    input logic                data_w_en,
    input logic                data_finish,
    input logic                ram_valid,
    input logic                f_done,
    input logic                d_done,
    input mem_pkg::arb_state_t arb_state
);
    import mem_pkg::*;

    // Both finish outputs are single-cycle pulses
    fetch_pulse: assert property (@(posedge clk) disable iff (rst)
        fetch_finish |=> !fetch_finish)
        else $error("fetch_finish high for more than one cycle");

    data_pulse: assert property (@(posedge clk) disable iff (rst)
        data_finish |=> !data_finish)
        else $error("data_finish high for more than one cycle");

    // An issue moves the arbiter into its response cycle, so no second issue follows
    issue_in_idle: assert property (@(posedge clk) disable iff (rst)
        ram_valid |=> arb_state == ARB_WAIT)
        else $error("ram_valid not followed by ARB_WAIT");

    // Every issue is answered in the next cycle by exactly one owner
    single_owner: assert property (@(posedge clk) disable iff (rst)
        ram_valid |=> $onehot({f_done, d_done}))
        else $error("issue not answered by exactly one of f_done and d_done");

    data_held: assert property (@(posedge clk) disable iff (rst)
        data_finish |-> (data_r_en || data_w_en))
        else $error("data_finish without a held data request");

endmodule

`default_nettype wire

// File: tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;
    import mem_pkg::*;

    typedef enum logic [1:0] {OP_FETCH, OP_LOAD, OP_STORE, OP_BOTH} op_t;

    // For OP_BOTH the fetch uses addr and the load uses addr2
    typedef struct {
        op_t   op;
        addr_t addr;
        addr_t addr2;
        word_t data;
        mask_t mask;
        int    max_lat;
    } entry_t;

    logic  clk;
    logic  rst;
    addr_t fetch_addr;
    logic  fetch_en;
    word_t fetch_data;
    logic  fetch_finish;
    addr_t data_addr;
    word_t data_wdata;
    mask_t data_mask;
    logic  data_r_en;
    logic  data_w_en;
    word_t data_rdata;
    logic  data_finish;

    entry_t      tbl[$];
    word_t       ref_mem [0:255];
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          cycles;

    mem_subsys #(
        .DEPTH_LOG2 (8)
    ) dut0 (
        .clk          (clk),
        .rst          (rst),
        .fetch_addr   (fetch_addr),
        .fetch_en     (fetch_en),
        .fetch_data   (fetch_data),
        .fetch_finish (fetch_finish),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_mask    (data_mask),
        .data_r_en    (data_r_en),
        .data_w_en    (data_w_en),
        .data_rdata   (data_rdata),
        .data_finish  (data_finish)
    );

    bind mem_subsys mem_subsys_asserts u_asserts (
        .clk          (clk),
        .rst          (rst),
        .fetch_finish (fetch_finish),
        .data_r_en    (data_r_en),
        .data_w_en    (data_w_en),
        .data_finish  (data_finish),
        .ram_valid    (ram_valid),
        .f_done       (f_done),
        .d_done       (d_done),
        .arb_state    (u_arb.state)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset, then at most eight cycles per entry, plus some slack
    initial begin
        cycles = 0;
        while (cycles <= 16 + 8 * tbl.size() + 50) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not end within %0d cycles", cycles - 1);
        $display("Regression failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_idle();
        compare("fetch_finish", {31'b0, fetch_finish}, 32'h0);
        compare("data_finish", {31'b0, data_finish}, 32'h0);
    endtask

    task automatic add_entry(input op_t op, input addr_t a, input addr_t a2,
                             input word_t d, input mask_t m, input int lat);
        entry_t e;
        e.op      = op;
        e.addr    = a;
        e.addr2   = a2;
        e.data    = d;
        e.mask    = m;
        e.max_lat = lat;
        tbl.push_back(e);
    endtask

    task automatic build_table();
        addr_t a;
        addr_t b;
        // Words 0 to 15 get written first so every later read is known
        for (int i = 0; i < 16; i++) begin
            rng_state = xorshift32(rng_state);
            add_entry(OP_STORE, addr_t'(4 * i), '0, rng_state, 4'hf, 1);
        end
        add_entry(OP_LOAD, 32'd12, '0, '0, 4'h0, 1);
        add_entry(OP_LOAD, 32'd28, '0, '0, 4'h0, 1);
        for (int k = 0; k < 4; k++) begin
            rng_state = xorshift32(rng_state);
            add_entry(OP_STORE, addr_t'(16 + k), '0, rng_state, 4'b0001, 1);
            add_entry(OP_LOAD, 32'd16, '0, '0, 4'h0, 1);
            rng_state = xorshift32(rng_state);
            add_entry(OP_STORE, addr_t'(20 + k), '0, rng_state, 4'b0011, 1);
            add_entry(OP_LOAD, 32'd20, '0, '0, 4'h0, 1);
        end
        // Words 9 to 12 at offsets 0 to 3
        for (int k = 0; k < 4; k++) begin
            add_entry(OP_LOAD, addr_t'(36 + 5 * k), '0, '0, 4'h0, 1);
        end
        // Miss, hit, store to the buffered word, then a fetch that must miss
        add_entry(OP_FETCH, 32'd8, '0, '0, 4'h0, 1);
        add_entry(OP_FETCH, 32'd8, '0, '0, 4'h0, 1);
        rng_state = xorshift32(rng_state);
        add_entry(OP_STORE, 32'd8, '0, rng_state, 4'hf, 1);
        add_entry(OP_FETCH, 32'd8, '0, '0, 4'h0, 1);
        for (int i = 0; i < 8; i++) begin
            rng_state = xorshift32(rng_state);
            a = {26'b0, rng_state[3:0], 2'b00};
            b = {26'b0, rng_state[7:4], rng_state[9:8]};
            add_entry(OP_BOTH, a, b, '0, 4'h0, 3);
        end
    endtask

    // Same lane rule as the data port: byte i takes store byte i-k
    task automatic apply_store(input addr_t a, input word_t d, input mask_t m);
        int k;
        k = int'(a[1:0]);
        for (int i = 0; i < LANES; i++) begin
            if (i >= k) begin
                if (m[i - k]) begin
                    ref_mem[a[9:2]][i*8 +: 8] = d[(i - k)*8 +: 8];
                end
            end
        end
    endtask

    task automatic run_entry(input int idx);
        entry_t e;
        addr_t  da;
        word_t  exp_f;
        word_t  exp_d;
        logic   f_pend;
        logic   d_pend;
        logic   f_fin;
        logic   d_fin;
        int     n;
        int     f_lat;
        int     d_lat;
        e      = tbl[idx];
        da     = (e.op == OP_BOTH) ? e.addr2 : e.addr;
        exp_f  = ref_mem[e.addr[9:2]];
        exp_d  = ref_mem[da[9:2]] >> {da[1:0], 3'b000};
        f_pend = (e.op == OP_FETCH) || (e.op == OP_BOTH);
        d_pend = (e.op != OP_FETCH);
        f_lat  = 0;
        d_lat  = 0;
        fetch_addr = e.addr;
        fetch_en   = f_pend;
        data_addr  = da;
        data_wdata = e.data;
        data_mask  = e.mask;
        data_r_en  = d_pend && (e.op != OP_STORE);
        data_w_en  = (e.op == OP_STORE);
        n = 0;
        while (f_pend || d_pend) begin
            @(negedge clk);
            f_fin = f_pend && fetch_finish;
            d_fin = d_pend && data_finish;
            if (f_fin) begin
                f_lat = n;
                compare("fetch_data", fetch_data, exp_f);
            end
            if (d_fin) begin
                d_lat = n;
                if (e.op == OP_STORE) begin
                    apply_store(da, e.data, e.mask);
                end else begin
                    compare("data_rdata", data_rdata, exp_d);
                end
            end
            @(posedge clk);
            #1;
            if (f_fin) begin
                fetch_en = 1'b0;
                f_pend   = 1'b0;
            end
            if (d_fin) begin
                data_r_en = 1'b0;
                data_w_en = 1'b0;
                d_pend    = 1'b0;
            end
            n++;
        end
        if (e.op == OP_BOTH) begin
            checks++;
            if (f_lat > e.max_lat || d_lat > e.max_lat) begin
                errors++;
                $display("Concurrent request finished too late: fetch after %0d, data after %0d",
                         f_lat, d_lat);
            end
        end else begin
            compare("finish latency", (e.op == OP_FETCH) ? f_lat : d_lat, e.max_lat);
        end
        $display("entry %0d %s done: fetch %0d, data %0d cycles, %0d errors so far",
                 idx, e.op.name(), f_lat, d_lat, errors);
    endtask

    initial begin
        rst        = 1'b1;
        fetch_addr = '0;
        fetch_en   = 1'b0;
        data_addr  = '0;
        data_wdata = '0;
        data_mask  = '0;
        data_r_en  = 1'b0;
        data_w_en  = 1'b0;
        errors     = 0;
        checks     = 0;
        rng_state  = 32'h88cc_2808;
        build_table();
        repeat (16) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        #1;
        for (int i = 0; i < tbl.size(); i++) begin
            run_entry(i);
            // One cycle with no request between entries
            @(negedge clk);
            check_idle();
            @(posedge clk);
            #1;
        end
        $display("%0d entries, %0d checks, %0d errors", tbl.size(), checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: word_ram.sv
`timescale 1ns/1ps
`default_nettype none

module word_ram #(
    parameter int DEPTH_LOG2 = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              ram_valid,
    input  mem_pkg::mem_req_t ram_req,
    output mem_pkg::word_t    ram_rdata,
    output logic              ram_ready
);
    import mem_pkg::*;

    word_t                 mem [0:(1 << DEPTH_LOG2)-1];
    logic [DEPTH_LOG2-1:0] idx;

    assign idx = ram_req.addr[DEPTH_LOG2+1:2];

    always_ff @(posedge clk) begin
        if (ram_valid && ram_req.write) begin
            for (int i = 0; i < LANES; i++) begin
                if (ram_req.mask[i]) begin
                    mem[idx][i*BYTE_W +: BYTE_W] <= ram_req.wdata[i*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    // A write also returns the old word, nobody looks at it
    always_ff @(posedge clk) begin
        if (ram_valid) begin
            ram_rdata <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ram_ready <= 1'b0;
        end else begin
            ram_ready <= ram_valid;
        end
    end

endmodule

`default_nettype wire
